//--- mem_system_pkg.sv
package mem_system_pkg;

   //////////////////////////////////////////////////
   // Address split
   //////////////////////////////////////////////////

   // Byte address = tag | index | beat | byte bit
   localparam int TAG_W   = 5;
   localparam int INDEX_W = 8;
   localparam int BEAT_W  = 2;

   // Data and address words
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;

   // Address fields
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [BEAT_W-1:0]  beat_t;

   //////////////////////////////////////////////////
   // Main memory timing
   //////////////////////////////////////////////////

   // Read data shows up this many cycles after rd
   localparam int MEM_LATENCY = 2;

   // Cycles before a bank takes another access
   localparam int BANK_BUSY = 4;

   //////////////////////////////////////////////////
   // Controller states
   //////////////////////////////////////////////////

   // Separate read and write paths through the request flow
   typedef enum logic [3:0] {
      IDLE         = 4'b0000,
      RD_COMPARE   = 4'b0001,
      RD_WRITEBACK = 4'b0101,
      RD_FILL      = 4'b0110,
      RD_RETURN    = 4'b0111,
      WR_COMPARE   = 4'b0100,
      WR_WRITEBACK = 4'b1001,
      WR_FILL      = 4'b1010,
      WR_RETURN    = 4'b1011
   } ctrl_state_t;

endpackage

//--- cache_way.sv
module cache_way (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable,
   input  logic                   comp,
   input  logic                   write,
   input  mem_system_pkg::tag_t   tag_in,
   input  mem_system_pkg::index_t index,
   input  mem_system_pkg::beat_t  beat,
   input  mem_system_pkg::word_t  data_in,
   output mem_system_pkg::tag_t   tag_out,
   output mem_system_pkg::word_t  data_out,
   output logic                   hit,
   output logic                   valid,
   output logic                   dirty
);
   import mem_system_pkg::*;

   localparam int SETS  = 2 ** INDEX_W;
   localparam int WORDS = 2 ** BEAT_W;

   // Per-set state
   tag_t  tag_mem   [SETS];
   logic  valid_mem [SETS];
   logic  dirty_mem [SETS];

   // Line storage, four words per set
   word_t line_mem [SETS][WORDS];

   // Write decode
   logic wr_access;
   logic wr_word;

   //////////////////////////////////////////////////
   // Combinational lookup
   //////////////////////////////////////////////////

   assign tag_out  = tag_mem[index];
   assign data_out = line_mem[index][beat];
   assign valid    = valid_mem[index];
   assign dirty    = dirty_mem[index];

   // Stored tag matches and line holds data
   assign hit = valid_mem[index] && (tag_mem[index] == tag_in);

   //////////////////////////////////////////////////
   // Write rules
   //////////////////////////////////////////////////

   // Access write, used by the line fill
   assign wr_access = enable && write && !comp;

   // Compare write lands only on a hit
   assign wr_word = wr_access || (enable && write && comp && hit);

   always_ff @(posedge clk) begin
      if (wr_word) begin
         line_mem[index][beat] <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < SETS; s++) begin
            tag_mem[s]   <= '0;
            valid_mem[s] <= 1'b0;
            dirty_mem[s] <= 1'b0;
         end
      end else if (wr_access) begin
         // Fresh line from memory, clean
         tag_mem[index]   <= tag_in;
         valid_mem[index] <= 1'b1;
         dirty_mem[index] <= 1'b0;
      end else if (wr_word) begin
         // CPU store on a hit
         dirty_mem[index] <= 1'b1;
      end
   end

endmodule

//--- way_select.sv
module way_select #(
   parameter int NUM_WAYS = 2
) (
   input  mem_system_pkg::tag_t  tag_in,
   input  logic                  victim,
   input  logic [NUM_WAYS-1:0]   hit,
   input  logic [NUM_WAYS-1:0]   valid,
   input  logic [NUM_WAYS-1:0]   dirty,
   input  mem_system_pkg::tag_t  tag_out [NUM_WAYS],
   input  mem_system_pkg::word_t data_out [NUM_WAYS],
   output logic                  real_hit,
   output logic                  victimize,
   output logic [NUM_WAYS-1:0]   fill_way,
   output mem_system_pkg::tag_t  sel_tag,
   output mem_system_pkg::word_t sel_data
);
   import mem_system_pkg::*;

   // One-hot vectors
   logic [NUM_WAYS-1:0] match;
   logic [NUM_WAYS-1:0] pick;

   assign real_hit = |hit;

   // Valid way holding the requested tag
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         match[w] = valid[w] && (tag_out[w] == tag_in);
      end
   end

   // Lowest invalid way first, else the victim way
   always_comb begin
      fill_way = '0;
      if (&valid) begin
         fill_way[victim] = 1'b1;
      end else begin
         for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
               fill_way    = '0;
               fill_way[w] = 1'b1;
            end
         end
      end
   end

   // Dirty line in the way about to be refilled
   assign victimize = |(fill_way & valid & dirty);

   //////////////////////////////////////////////////
   // Output mux
   //////////////////////////////////////////////////

   assign pick = (|match) ? match : fill_way;

   always_comb begin
      sel_tag  = '0;
      sel_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (pick[w]) begin
            sel_tag  = tag_out[w];
            sel_data = data_out[w];
         end
      end
   end

endmodule

//--- four_bank_mem.sv
module four_bank_mem (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out
);
   import mem_system_pkg::*;

   localparam int BANKS  = 2 ** BEAT_W;
   localparam int ROW_W  = TAG_W + INDEX_W;
   localparam int BUSY_W = $clog2(BANK_BUSY);

   // Banks interleaved on the word number
   word_t bank_mem [BANKS][2 ** ROW_W];

   // Read return pipe
   word_t rd_pipe [MEM_LATENCY];

   // Cycles left before each bank is free
   logic [BUSY_W-1:0] busy_cnt [BANKS];

   beat_t            bank;
   logic [ROW_W-1:0] row;

   assign bank = addr[BEAT_W:1];
   assign row  = addr[15:BEAT_W+1];

   // Power-up contents
   initial begin
      for (int b = 0; b < BANKS; b++) begin
         for (int r = 0; r < 2 ** ROW_W; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Array and read pipe
   //////////////////////////////////////////////////

   // Write completes in its own cycle
   always @(posedge clk) begin
      if (wr) begin
         bank_mem[bank][row] <= data_in;
      end
   end

   // Several reads may be in flight
   always_ff @(posedge clk) begin
      if (rd) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      for (int i = 1; i < MEM_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign data_out = rd_pipe[MEM_LATENCY-1];

   //////////////////////////////////////////////////
   // Bank busy timers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if ((rd || wr) && (bank == beat_t'(b))) begin
               busy_cnt[b] <= BUSY_W'(BANK_BUSY - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Controller spacing must keep a bank idle for BANK_BUSY cycles
   a_bank_free : assert property (@(posedge clk) disable iff (rst)
      (rd || wr) |-> (busy_cnt[bank] == '0));

endmodule

//--- cache_ctrl.sv
module cache_ctrl #(
   parameter int NUM_WAYS = 2
) (
   input  logic                   clk,
   input  logic                   rst,
   // CPU side
   input  mem_system_pkg::addr_t  addr,
   input  mem_system_pkg::word_t  data_in,
   input  logic                   rd,
   input  logic                   wr,
   output mem_system_pkg::word_t  data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err,
   // Shared way drive
   output logic [NUM_WAYS-1:0]    way_en,
   output logic                   way_comp,
   output logic                   way_write,
   output mem_system_pkg::tag_t   way_tag,
   output mem_system_pkg::index_t way_index,
   output mem_system_pkg::beat_t  way_beat,
   output mem_system_pkg::word_t  way_data,
   // Way selector
   input  logic                   real_hit,
   input  logic                   victimize,
   input  logic [NUM_WAYS-1:0]    fill_way,
   input  mem_system_pkg::tag_t   sel_tag,
   input  mem_system_pkg::word_t  sel_data,
   output logic                   victim,
   // Main memory
   output mem_system_pkg::addr_t  mem_addr,
   output mem_system_pkg::word_t  mem_data_in,
   output logic                   mem_rd,
   output logic                   mem_wr,
   input  mem_system_pkg::word_t  mem_data_out
);
   import mem_system_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;

   // Request held while the CPU moves on
   addr_t req_addr;
   word_t req_data;

   // Beat counter, 0..3 for write-back, 0..5 for fill
   logic [2:0] cnt;

   logic                victim_q;
   logic [NUM_WAYS-1:0] fill_en;

   // State groups
   logic in_compare;
   logic in_wb;
   logic in_fill;
   logic in_return;

   // Captured address fields
   tag_t   req_tag;
   index_t req_index;
   beat_t  req_beat;
   beat_t  fill_beat;

   assign {req_tag, req_index, req_beat} = req_addr[15:1];

   assign in_compare = (state == RD_COMPARE)   || (state == WR_COMPARE);
   assign in_wb      = (state == RD_WRITEBACK) || (state == WR_WRITEBACK);
   assign in_fill    = (state == RD_FILL)      || (state == WR_FILL);
   assign in_return  = (state == RD_RETURN)    || (state == WR_RETURN);

   // Fill data trails its read by MEM_LATENCY
   assign fill_beat = beat_t'(cnt - 3'(MEM_LATENCY));

   //////////////////////////////////////////////////
   // State and counters
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         req_addr <= '0;
         cnt      <= '0;
         victim_q <= 1'b0;
         fill_en  <= '0;
      end else begin
         state <= next_state;
         if (state == IDLE) begin
            req_addr <= addr;
         end
         if (in_wb) begin
            cnt <= (cnt == 3'd3) ? 3'd0 : cnt + 3'd1;
         end else if (in_fill) begin
            cnt <= cnt + 3'd1;
         end else begin
            cnt <= '0;
         end
         // Flip on every lookup, hit or miss
         if (in_compare) begin
            victim_q <= ~victim_q;
            if (!real_hit) begin
               fill_en <= fill_way;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         req_data <= data_in;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (rd) begin
               next_state = RD_COMPARE;
            end else if (wr) begin
               next_state = WR_COMPARE;
            end
         end
         RD_COMPARE: begin
            next_state = real_hit ? IDLE : (victimize ? RD_WRITEBACK : RD_FILL);
         end
         WR_COMPARE: begin
            next_state = real_hit ? IDLE : (victimize ? WR_WRITEBACK : WR_FILL);
         end
         RD_WRITEBACK: begin
            if (cnt == 3'd3) begin
               next_state = RD_FILL;
            end
         end
         WR_WRITEBACK: begin
            if (cnt == 3'd3) begin
               next_state = WR_FILL;
            end
         end
         // Four reads plus the latency tail
         RD_FILL: begin
            if (cnt == 3'd5) begin
               next_state = RD_RETURN;
            end
         end
         WR_FILL: begin
            if (cnt == 3'd5) begin
               next_state = WR_RETURN;
            end
         end
         default: next_state = IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // CPU outputs
   //////////////////////////////////////////////////

   assign stall     = (state == IDLE) ? (rd || wr) : 1'b1;
   assign done      = (in_compare && real_hit) || in_return;
   assign cache_hit = in_compare && real_hit;
   assign data_out  = sel_data;

   // Byte bit is ignored for the access itself
   assign err = req_addr[0];

   //////////////////////////////////////////////////
   // Way drive
   //////////////////////////////////////////////////

   // All ways look up, only the fill way is touched afterwards
   assign way_en = in_compare ? '1 : ((in_wb || in_fill || in_return) ? fill_en : '0);

   // Store after refill goes through compare write to set dirty
   assign way_comp  = in_compare || (state == WR_RETURN);
   assign way_write = (state == WR_COMPARE) || (state == WR_RETURN) ||
                      (in_fill && (cnt >= 3'(MEM_LATENCY)));

   assign way_tag   = req_tag;
   assign way_index = req_index;
   assign way_beat  = in_wb ? cnt[1:0] : (in_fill ? fill_beat : req_beat);
   assign way_data  = in_fill ? mem_data_out : req_data;

   // Register has already flipped once past compare
   assign victim = in_compare ? victim_q : ~victim_q;

   //////////////////////////////////////////////////
   // Memory drive
   //////////////////////////////////////////////////

   // Old line goes back under its own tag
   assign mem_addr    = in_wb ? {sel_tag, req_index, cnt[1:0], 1'b0}
                              : {req_tag, req_index, cnt[1:0], 1'b0};
   assign mem_data_in = sel_data;
   assign mem_wr      = in_wb;
   assign mem_rd      = in_fill && (cnt < 3'd4);

   // Completion only from a lookup or a return, then back to IDLE
   a_done_state : assert property (@(posedge clk) disable iff (rst)
      done |-> (in_compare || in_return) ##1 (state == IDLE));

   a_mem_excl : assert property (@(posedge clk) disable iff (rst)
      !(mem_rd && mem_wr));

endmodule

//--- mem_system.sv
module mem_system #(
   parameter int NUM_WAYS = 2
) (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);
   import mem_system_pkg::*;

   // Controller to ways
   logic [NUM_WAYS-1:0] way_en;
   logic                way_comp;
   logic                way_write;
   tag_t                way_tag;
   index_t              way_index;
   beat_t               way_beat;
   word_t               way_data;

   // Ways to selector
   logic [NUM_WAYS-1:0] way_hit;
   logic [NUM_WAYS-1:0] way_valid;
   logic [NUM_WAYS-1:0] way_dirty;
   tag_t                way_tag_out  [NUM_WAYS];
   word_t               way_data_out [NUM_WAYS];

   // Selector to controller
   logic                real_hit;
   logic                victimize;
   logic                victim;
   logic [NUM_WAYS-1:0] fill_way;
   tag_t                sel_tag;
   word_t               sel_data;

   // Memory bus
   addr_t mem_addr;
   word_t mem_data_in;
   word_t mem_data_out;
   logic  mem_rd;
   logic  mem_wr;

   cache_ctrl #(.NUM_WAYS(NUM_WAYS)) ctrl (
      .clk, .rst, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err,
      .way_en, .way_comp, .way_write, .way_tag, .way_index, .way_beat, .way_data,
      .real_hit, .victimize, .fill_way, .sel_tag, .sel_data, .victim,
      .mem_addr, .mem_data_in, .mem_rd, .mem_wr, .mem_data_out
   );

   // Identical ways on one shared drive
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      cache_way way (
         .clk      (clk),
         .rst      (rst),
         .enable   (way_en[w]),
         .comp     (way_comp),
         .write    (way_write),
         .tag_in   (way_tag),
         .index    (way_index),
         .beat     (way_beat),
         .data_in  (way_data),
         .tag_out  (way_tag_out[w]),
         .data_out (way_data_out[w]),
         .hit      (way_hit[w]),
         .valid    (way_valid[w]),
         .dirty    (way_dirty[w])
      );
   end

   way_select #(.NUM_WAYS(NUM_WAYS)) sel (
      .tag_in    (way_tag),
      .victim    (victim),
      .hit       (way_hit),
      .valid     (way_valid),
      .dirty     (way_dirty),
      .tag_out   (way_tag_out),
      .data_out  (way_data_out),
      .real_hit  (real_hit),
      .victimize (victimize),
      .fill_way  (fill_way),
      .sel_tag   (sel_tag),
      .sel_data  (sel_data)
   );

   four_bank_mem mem (
      .clk      (clk),
      .rst      (rst),
      .addr     (mem_addr),
      .data_in  (mem_data_in),
      .rd       (mem_rd),
      .wr       (mem_wr),
      .data_out (mem_data_out)
   );

endmodule

//--- tb_mem_system.sv
module tb_mem_system;
   import mem_system_pkg::*;

   localparam int WAYS         = 2;
   localparam int SETS         = 2 ** INDEX_W;
   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   localparam int DONE_LIMIT   = 20;

   // Latency counted in edges after the accept edge
   localparam int LAT_HIT   = 1;
   // Compare, four reads, read latency, return
   localparam int LAT_MISS  = 1 + 4 + MEM_LATENCY + 1;
   // Four write-back beats come first
   localparam int LAT_EVICT = LAT_MISS + 4;

   // Requests per test
   localparam int N_COLD     = 4;
   localparam int N_PAIRS    = 4;
   localparam int N_EVICT    = 7;
   localparam int N_VICTIM   = 10;
   localparam int N_RANDOM   = 300;
   localparam int N_MISALIGN = 3;
   localparam int NUM_REQS   = N_COLD + 2 * N_PAIRS + N_EVICT + N_VICTIM + N_RANDOM + N_MISALIGN;
   // Extra idle cycles for the misaligned test plus margin
   localparam int WATCHDOG_TIME = (NUM_REQS * DONE_LIMIT + RESET_CYCLES + 8) * CLK_PERIOD;

   logic  clk = 1'b0;
   logic  rst;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   mem_system #(.NUM_WAYS(WAYS)) UUT (
      .clk, .rst, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // Reference state
   //////////////////////////////////////////////////

   // One entry per word of CPU-visible memory
   word_t ref_mem [2 ** 15];

   // Shadow directory
   tag_t sh_tag   [WAYS][SETS];
   logic sh_valid [WAYS][SETS];
   logic sh_dirty [WAYS][SETS];
   logic sh_victim;

   logic [31:0] seed = 32'he656;

   // Expectations handed to the compare process
   string name_q  [$];
   logic  is_rd_q [$];
   word_t data_q  [$];
   logic  hit_q   [$];
   logic  err_q   [$];
   int    lat_q   [$];
   int    n_issued  = 0;
   int    n_checked = 0;

   int data_errs  = 0;
   int hit_errs   = 0;
   int lat_errs   = 0;
   int flag_errs  = 0;
   int other_errs = 0;

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 7;
   endfunction

   function automatic addr_t make_addr(input tag_t t, input index_t idx, input beat_t b,
                                       input logic byte_bit);
      return {t, idx, b, byte_bit};
   endfunction

   // Predicts data, hit and latency and advances the shadow state
   function automatic int predict_access(input logic is_wr, input addr_t a, input word_t d,
                                         output word_t exp_data, output logic exp_hit);
      tag_t   t;
      index_t idx;
      int     way;
      int     lat;
      logic   vict;
      t   = a[15:11];
      idx = a[10:3];
      way = -1;
      for (int w = 0; w < WAYS; w++) begin
         if (sh_valid[w][idx] && (sh_tag[w][idx] == t)) begin
            way = w;
         end
      end
      // Victim bit flips on every lookup
      vict      = sh_victim;
      sh_victim = ~sh_victim;
      exp_hit   = (way >= 0);
      if (exp_hit) begin
         lat = LAT_HIT;
      end else begin
         // Lowest invalid way or else the victim way
         way = int'(vict);
         for (int w = WAYS - 1; w >= 0; w--) begin
            if (!sh_valid[w][idx]) begin
               way = w;
            end
         end
         lat = (sh_valid[way][idx] && sh_dirty[way][idx]) ? LAT_EVICT : LAT_MISS;
         sh_tag[way][idx]   = t;
         sh_valid[way][idx] = 1'b1;
         sh_dirty[way][idx] = 1'b0;
      end
      if (is_wr) begin
         ref_mem[a[15:1]]   = d;
         sh_dirty[way][idx] = 1'b1;
      end
      exp_data = ref_mem[a[15:1]];
      return lat;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("[FAIL] %s: data expected %h, actual %h", name, exp, act);
         data_errs++;
      end
   endtask

   task automatic check_hit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[FAIL] %s: cache_hit expected %b, actual %b", name, exp, act);
         hit_errs++;
      end
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      if (exp != act) begin
         $display("[FAIL] %s: latency expected %0d, actual %0d", name, exp, act);
         lat_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
         flag_errs++;
      end
   endtask

   // Issue one request and wait until its response is checked
   task automatic issue_req(input string name, input logic is_wr, input addr_t a,
                            input word_t d);
      word_t e_data;
      logic  e_hit;
      int    e_lat;
      @(posedge clk);
      rd      <= !is_wr;
      wr      <= is_wr;
      addr    <= a;
      data_in <= d;
      // Accept edge
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      e_lat = predict_access(is_wr, a, d, e_data, e_hit);
      name_q.push_back(name);
      is_rd_q.push_back(!is_wr);
      data_q.push_back(e_data);
      hit_q.push_back(e_hit);
      err_q.push_back(a[0]);
      lat_q.push_back(e_lat);
      n_issued++;
      wait (n_checked == n_issued);
   endtask

   //////////////////////////////////////////////////
   // Response checking
   //////////////////////////////////////////////////

   initial begin : compare_proc
      string name;
      logic  is_rd;
      word_t e_data;
      logic  e_hit;
      logic  e_err;
      int    e_lat;
      int    cycles;
      logic  got;
      forever begin
         wait (n_issued != n_checked);
         name   = name_q.pop_front();
         is_rd  = is_rd_q.pop_front();
         e_data = data_q.pop_front();
         e_hit  = hit_q.pop_front();
         e_err  = err_q.pop_front();
         e_lat  = lat_q.pop_front();
         cycles = 0;
         got    = 1'b0;
         // Outputs sampled mid-cycle
         while (!got && (cycles < DONE_LIMIT)) begin
            @(negedge clk);
            cycles++;
            got = done;
         end
         if (got) begin
            if (is_rd) begin
               check_word(name, e_data, data_out);
            end
            check_hit(name, e_hit, cache_hit);
            check_flag({name, " err"}, e_err, err);
            check_flag({name, " stall"}, 1'b1, stall);
            check_latency(name, e_lat, cycles);
         end else begin
            $display("%s: the DUT gave no done within %0d cycles", name, DONE_LIMIT);
            other_errs++;
         end
         n_checked++;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_TIME);
      $display("Watchdog expired after %0d time units, the run is stuck", WATCHDOG_TIME);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin : main_proc
      logic [31:0] r;
      addr_t       a;
      word_t       d;
      tag_t        seq [N_VICTIM];
      int          total;
      rst     <= 1'b1;
      rd      <= 1'b0;
      wr      <= 1'b0;
      addr    <= '0;
      data_in <= '0;
      for (int i = 0; i < 2 ** 15; i++) begin
         ref_mem[i] = '0;
      end
      for (int w = 0; w < WAYS; w++) begin
         for (int s = 0; s < SETS; s++) begin
            sh_tag[w][s]   = '0;
            sh_valid[w][s] = 1'b0;
            sh_dirty[w][s] = 1'b0;
         end
      end
      sh_victim = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // Cold reads return zero
      issue_req("cold 0", 1'b0, make_addr(5'h03, 8'h21, 2'd1, 1'b0), '0);
      issue_req("cold 1", 1'b0, make_addr(5'h1f, 8'hff, 2'd3, 1'b0), '0);
      issue_req("cold 2", 1'b0, make_addr(5'h00, 8'h00, 2'd0, 1'b0), '0);
      issue_req("cold 3", 1'b0, make_addr(5'h11, 8'h80, 2'd2, 1'b0), '0);

      // Write then read back with a hit
      for (int p = 0; p < N_PAIRS; p++) begin
         r = next_rand();
         a = make_addr(tag_t'(r[4:0]), index_t'(r[12:5]), beat_t'(r[14:13]), 1'b0);
         d = word_t'(next_rand());
         issue_req($sformatf("pair %0d write", p), 1'b1, a, d);
         issue_req($sformatf("pair %0d read", p), 1'b0, a, '0);
      end

      // Third tag in one set evicts a dirty line
      issue_req("evict w t1b0", 1'b1, make_addr(5'h01, 8'h5a, 2'd0, 1'b0), 16'h1111);
      issue_req("evict w t1b3", 1'b1, make_addr(5'h01, 8'h5a, 2'd3, 1'b0), 16'h1333);
      issue_req("evict w t2b1", 1'b1, make_addr(5'h02, 8'h5a, 2'd1, 1'b0), 16'h2222);
      issue_req("evict w t3b2", 1'b1, make_addr(5'h03, 8'h5a, 2'd2, 1'b0), 16'h3333);
      issue_req("evict r t1b0", 1'b0, make_addr(5'h01, 8'h5a, 2'd0, 1'b0), '0);
      issue_req("evict r t1b3", 1'b0, make_addr(5'h01, 8'h5a, 2'd3, 1'b0), '0);
      issue_req("evict r t2b1", 1'b0, make_addr(5'h02, 8'h5a, 2'd1, 1'b0), '0);

      // Three tags rotating through two ways
      seq = '{5'd4, 5'd5, 5'd6, 5'd4, 5'd5, 5'd6, 5'd6, 5'd4, 5'd5, 5'd4};
      for (int i = 0; i < N_VICTIM; i++) begin
         a = make_addr(seq[i], 8'hc3, beat_t'(i % 4), 1'b0);
         issue_req($sformatf("victim %0d", i), (i % 3) == 1, a, word_t'(16'h4000 + i));
      end

      // Random mix over four tags and four sets
      for (int i = 0; i < N_RANDOM; i++) begin
         r = next_rand();
         a = make_addr(tag_t'(r[1:0]), index_t'({6'h10, r[3:2]}), beat_t'(r[5:4]), 1'b0);
         d = word_t'(next_rand());
         issue_req($sformatf("random %0d", i), r[8], a, d);
      end

      // Odd address while idle without a request
      @(posedge clk);
      addr <= 16'h2461;
      @(posedge clk);
      @(negedge clk);
      check_flag("idle err", 1'b1, err);
      check_flag("idle stall", 1'b0, stall);
      // Byte bit ignored by the access
      issue_req("misaligned read", 1'b0, 16'h2461, '0);
      issue_req("misaligned write", 1'b1, 16'h2463, 16'hbeef);
      issue_req("aligned read", 1'b0, 16'h2462, '0);

      total = data_errs + hit_errs + lat_errs + flag_errs + other_errs;
      $display("Errors: data %0d, hit %0d, latency %0d, flag %0d, other %0d",
               data_errs, hit_errs, lat_errs, flag_errs, other_errs);
      if (total == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- mem_system.f
mem_system_pkg.sv
cache_way.sv
way_select.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_system -f mem_system.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_mem_system)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
   exit 0
fi
exit 1
